// ==== verilog/exec_pkg.sv ====
// --------------------
// Execute stage package
// Widths, word types and the ALU and CFU operation encodings
// --------------------

package exec_pkg;

    // --------------------
    // Widths
    localparam int XLEN       = 32;            // Data path width
    localparam int REG_ADDR_W = 5;             // GPR address bits
    localparam int SHAMT_W    = $clog2(XLEN);  // Shift amount bits

    // --------------------
    // Word types
    typedef logic [XLEN-1:0]       word_t;      // Operand, PC, result, target
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register address

    // --------------------
    // ALU operations
    typedef enum logic [3:0] {
        ALU_OP_NOP  = 4'd0,     // No result, no write
        ALU_OP_ADD  = 4'd1,
        ALU_OP_SUB  = 4'd2,
        ALU_OP_XOR  = 4'd3,
        ALU_OP_OR   = 4'd4,
        ALU_OP_AND  = 4'd5,
        ALU_OP_SLT  = 4'd6,     // Signed set less than
        ALU_OP_SLTU = 4'd7,     // Unsigned set less than
        ALU_OP_SRL  = 4'd8,
        ALU_OP_SLL  = 4'd9,
        ALU_OP_SRA  = 4'd10     // Sign filled right shift
    } alu_op_t;

    // --------------------
    // Control flow operations
    typedef enum logic [3:0] {
        CFU_OP_NOP  = 4'd0,     // Sequential instruction
        CFU_OP_J    = 4'd1,     // Jump, no link
        CFU_OP_JAL  = 4'd2,     // Jump and link
        CFU_OP_JALR = 4'd3,     // Register jump and link
        CFU_OP_BEQ  = 4'd4,
        CFU_OP_BNE  = 4'd5,
        CFU_OP_BLT  = 4'd6,     // Signed compares
        CFU_OP_BLTU = 4'd7,     // Unsigned compares
        CFU_OP_BGE  = 4'd8,
        CFU_OP_BGEU = 4'd9
    } cfu_op_t;

endpackage

// ==== verilog/exec_alu.sv ====
// --------------------
// Execute stage integer ALU
// Purely combinational, with compare flags and the raw adder output
// --------------------

module exec_alu (
    input  exec_pkg::word_t   opr_a,    // Operand A
    input  exec_pkg::word_t   opr_b,    // Operand B
    input  exec_pkg::alu_op_t alu_op,   // Operation select
    output exec_pkg::word_t   result,   // Operation result
    output exec_pkg::word_t   add_out,  // Adder output, also jump target
    output logic              cmp_eq,   // opr_a == opr_b
    output logic              cmp_lt,   // opr_a <  opr_b signed
    output logic              cmp_ltu   // opr_a <  opr_b unsigned
);

    // --------------------
    // Shared adder and subtractor
    logic                         op_sub;   // Subtract select
    exec_pkg::word_t              add_b;    // Adder B input, maybe inverted
    logic [exec_pkg::SHAMT_W-1:0] shamt;    // Low bits of operand B

    assign op_sub  = alu_op == exec_pkg::ALU_OP_SUB;
    assign add_b   = op_sub ? ~opr_b : opr_b;                         // Two's complement
    assign add_out = opr_a + add_b + {{(exec_pkg::XLEN-1){1'b0}}, op_sub}; // Carry in

    // --------------------
    // Compares
    assign cmp_eq  = opr_a == opr_b;
    assign cmp_lt  = $signed(opr_a) < $signed(opr_b);   // For SLT, BLT, BGE
    assign cmp_ltu = opr_a < opr_b;                     // For SLTU, BLTU, BGEU

    assign shamt   = opr_b[exec_pkg::SHAMT_W-1:0];

    // --------------------
    // Result select
    always_comb begin
        case (alu_op)
            exec_pkg::ALU_OP_ADD,
            exec_pkg::ALU_OP_SUB: begin
                result = add_out;                       // Sum or difference
            end
            exec_pkg::ALU_OP_XOR:  result = opr_a ^ opr_b;
            exec_pkg::ALU_OP_OR:   result = opr_a | opr_b;
            exec_pkg::ALU_OP_AND:  result = opr_a & opr_b;
            exec_pkg::ALU_OP_SLT: begin
                result = {{(exec_pkg::XLEN-1){1'b0}}, cmp_lt};  // Zero extended flag
            end
            exec_pkg::ALU_OP_SLTU: begin
                result = {{(exec_pkg::XLEN-1){1'b0}}, cmp_ltu};
            end
            exec_pkg::ALU_OP_SRL:  result = opr_a >> shamt;
            exec_pkg::ALU_OP_SLL:  result = opr_a << shamt;
            exec_pkg::ALU_OP_SRA: begin
                result = $signed(opr_a) >>> shamt;      // Sign fill
            end
            default: begin
                result = '0;                            // NOP and unused codes
            end
        endcase
    end

endmodule

// ==== verilog/exec_cfu.sv ====
// --------------------
// Execute stage control flow unit
// Branch decision, target select, fetch request and stage ready
// --------------------

module exec_cfu (
    input  logic              g_clk,         // Clock
    input  logic              g_resetn,      // Sync reset, active low
    input  logic              s2_valid,      // Instruction present
    input  logic              s2_cf_ack,     // Fetch took the change
    input  exec_pkg::cfu_op_t s2_cfu_op,     // Control flow operation
    input  exec_pkg::word_t   s2_pc,         // Instruction PC
    input  exec_pkg::word_t   s2_opr_c,      // Branch offset
    input  exec_pkg::word_t   add_out,       // opr_a + opr_b from ALU
    input  logic              cmp_eq,        // ALU flags
    input  logic              cmp_lt,
    input  logic              cmp_ltu,
    output logic              s2_cf_valid,   // Control flow change request
    output logic              s2_ready,      // Ready for next instruction
    output logic              cfu_link_wen,  // Link value goes to rd
    output exec_pkg::word_t   s2_cf_target   // Change destination
);

    // --------------------
    // Operation decode
    logic op_j;
    logic op_jal;
    logic op_jalr;
    logic op_jump;          // Unconditional change
    logic op_cond;          // Any conditional branch
    logic cond_taken;       // Branch condition holds
    logic cf_change;        // This instruction changes flow
    logic cf_pend;          // Change still owed to fetch
    logic cf_done;          // Change acked for current instruction
    logic e_accept;         // Decode hands over next instruction
    logic e_cf_change;      // Fetch takes the change this cycle

    assign op_j    = s2_cfu_op == exec_pkg::CFU_OP_J;
    assign op_jal  = s2_cfu_op == exec_pkg::CFU_OP_JAL;
    assign op_jalr = s2_cfu_op == exec_pkg::CFU_OP_JALR;
    assign op_jump = op_j || op_jal || op_jalr;

    assign op_cond = s2_cfu_op inside {exec_pkg::CFU_OP_BEQ,  exec_pkg::CFU_OP_BNE,
                                       exec_pkg::CFU_OP_BLT,  exec_pkg::CFU_OP_BLTU,
                                       exec_pkg::CFU_OP_BGE,  exec_pkg::CFU_OP_BGEU};

    // --------------------
    // Branch decision
    always_comb begin
        case (s2_cfu_op)
            exec_pkg::CFU_OP_BEQ:  cond_taken =  cmp_eq;
            exec_pkg::CFU_OP_BNE:  cond_taken = !cmp_eq;
            exec_pkg::CFU_OP_BLT:  cond_taken =  cmp_lt;
            exec_pkg::CFU_OP_BLTU: cond_taken =  cmp_ltu;
            exec_pkg::CFU_OP_BGE:  cond_taken = !cmp_lt;    // Signed greater or equal
            exec_pkg::CFU_OP_BGEU: cond_taken = !cmp_ltu;
            default:               cond_taken = 1'b0;       // Jumps handled apart
        endcase
    end

    assign cf_change = op_jump || (op_cond && cond_taken);
    assign cf_pend   = cf_change && !cf_done;

    // --------------------
    // Fetch request
    assign s2_cf_valid  = s2_valid && cf_pend;              // Held until ack
    assign s2_cf_target = op_cond ? s2_pc + s2_opr_c :
                          add_out & {{(exec_pkg::XLEN-1){1'b1}}, !op_jalr}; // JALR drops bit 0

    assign e_cf_change  = s2_cf_valid && s2_cf_ack;
    assign e_accept     = s2_valid && s2_ready;

    // Stops a second change to the same target while decode still holds it
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else if (e_accept) begin
            cf_done <= 1'b0;                                // New instruction next
        end else if (e_cf_change) begin
            cf_done <= 1'b1;
        end
    end

    assign s2_ready     = !cf_pend && !s2_cf_valid;         // One cycle after ack at best
    assign cfu_link_wen = op_jal || op_jalr;                // Link write for JAL/JALR

endmodule

// ==== verilog/exec_writeback.sv ====
// --------------------
// Execute stage register writeback
// Picks ALU or link data, one write per instruction
// --------------------

module exec_writeback (
    input  logic                g_clk,          // Clock
    input  logic                g_resetn,       // Sync reset, active low
    input  logic                s2_valid,       // Instruction present
    input  logic                s2_ready,       // Stage can accept next
    input  logic                cfu_link_wen,   // JAL/JALR link write
    input  exec_pkg::alu_op_t   s2_alu_op,      // ALU operation
    input  exec_pkg::reg_addr_t s2_rd,          // Destination register
    input  exec_pkg::word_t     alu_result,     // ALU output
    input  exec_pkg::word_t     s2_opr_c,       // Link value, pc+4
    output logic                s2_rd_wen,      // Write strobe
    output exec_pkg::reg_addr_t s2_rd_addr,     // Write address
    output exec_pkg::word_t     s2_rd_wdata     // Write data
);

    logic alu_wen;      // ALU result wants rd
    logic rd_done;      // Write already issued for this instruction
    logic e_accept;     // Instruction leaves the stage

    assign alu_wen  = (s2_alu_op != exec_pkg::ALU_OP_NOP) && !cfu_link_wen;
    assign e_accept = s2_valid && s2_ready;

    // --------------------
    // Write strobe
    assign s2_rd_wen   = s2_valid && !rd_done && (alu_wen || cfu_link_wen);
    assign s2_rd_addr  = s2_rd;
    assign s2_rd_wdata = cfu_link_wen ? s2_opr_c : alu_result;  // Link wins

    // Guard against repeat writes while stalled on fetch
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rd_done <= 1'b0;
        end else if (e_accept) begin
            rd_done <= 1'b0;                // Fresh instruction next cycle
        end else if (s2_rd_wen) begin
            rd_done <= 1'b1;
        end
    end

endmodule

// ==== verilog/exec_stage.sv ====
// --------------------
// Execute stage top
// ALU, control flow unit and register writeback
// --------------------

module exec_stage (
    input  logic                g_clk,          // Clock
    input  logic                g_resetn,       // Sync reset, active low
    input  logic                s2_valid,       // Decode has an instruction
    input  exec_pkg::word_t     s2_pc,          // Instruction PC
    input  exec_pkg::word_t     s2_opr_a,       // Operand A
    input  exec_pkg::word_t     s2_opr_b,       // Operand B
    input  exec_pkg::word_t     s2_opr_c,       // Link value or branch offset
    input  exec_pkg::reg_addr_t s2_rd,          // Destination register
    input  exec_pkg::alu_op_t   s2_alu_op,      // ALU operation
    input  exec_pkg::cfu_op_t   s2_cfu_op,      // Control flow operation
    output logic                s2_ready,       // Ready for next instruction
    output logic                s2_cf_valid,    // Control flow change to fetch
    input  logic                s2_cf_ack,      // Fetch acknowledge
    output exec_pkg::word_t     s2_cf_target,   // Change destination
    output logic                s2_rd_wen,      // GPR write strobe
    output exec_pkg::reg_addr_t s2_rd_addr,     // GPR write address
    output exec_pkg::word_t     s2_rd_wdata     // GPR write data
);

    exec_pkg::word_t alu_result;    // ALU to writeback
    exec_pkg::word_t alu_add_out;   // ALU adder to CFU
    logic            cmp_eq;        // Compare flags
    logic            cmp_lt;
    logic            cmp_ltu;
    logic            cfu_link_wen;  // CFU to writeback

    // --------------------
    // Units
    exec_alu i_exec_alu (
        .opr_a   (s2_opr_a),
        .opr_b   (s2_opr_b),
        .alu_op  (s2_alu_op),
        .result  (alu_result),
        .add_out (alu_add_out),
        .cmp_eq  (cmp_eq),
        .cmp_lt  (cmp_lt),
        .cmp_ltu (cmp_ltu)
    );

    exec_cfu i_exec_cfu (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s2_valid     (s2_valid),
        .s2_cf_ack    (s2_cf_ack),
        .s2_cfu_op    (s2_cfu_op),
        .s2_pc        (s2_pc),
        .s2_opr_c     (s2_opr_c),
        .add_out      (alu_add_out),
        .cmp_eq       (cmp_eq),
        .cmp_lt       (cmp_lt),
        .cmp_ltu      (cmp_ltu),
        .s2_cf_valid  (s2_cf_valid),
        .s2_ready     (s2_ready),
        .cfu_link_wen (cfu_link_wen),
        .s2_cf_target (s2_cf_target)
    );

    exec_writeback i_exec_writeback (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s2_valid     (s2_valid),
        .s2_ready     (s2_ready),       // Acceptance clears the write guard
        .cfu_link_wen (cfu_link_wen),
        .s2_alu_op    (s2_alu_op),
        .s2_rd        (s2_rd),
        .alu_result   (alu_result),
        .s2_opr_c     (s2_opr_c),
        .s2_rd_wen    (s2_rd_wen),
        .s2_rd_addr   (s2_rd_addr),
        .s2_rd_wdata  (s2_rd_wdata)
    );

endmodule

// ==== test/exec_tb_clock.sv ====
// --------------------
// Testbench clock and reset
// Free running clock, synchronous reset held for a set number of cycles
// --------------------

module exec_tb_clock #(
    parameter int PERIOD_NS     = 8,        // Clock period
    parameter int RESET_CYCLES  = 16,       // Cycles with reset low
    parameter int RELEASE_DELAY = 1         // ns after the edge
) (
    output logic g_clk,
    output logic g_resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        g_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) g_clk = ~g_clk;    // Half period toggle
        end
    end

    initial begin
        g_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #RELEASE_DELAY;
        g_resetn = 1'b1;                        // Released off the edge
    end

endmodule

// ==== test/exec_assert.sv ====
// --------------------
// Execute stage handshake assertions
// Fetch request hold, single register write, ready after ack
// --------------------

module exec_assert (
    input logic            g_clk,
    input logic            g_resetn,
    input logic            s2_valid,
    input logic            s2_ready,
    input logic            s2_cf_valid,
    input logic            s2_cf_ack,
    input exec_pkg::word_t s2_cf_target,
    input logic            s2_rd_wen
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;    // Read by the testbench summary

    // Request stays up with a steady target until fetch takes it
    cf_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid && !s2_cf_ack |=> s2_cf_valid && $stable(s2_cf_target))
    else begin
        $error("Control flow request dropped or target moved before ack");
        fail_count++;
    end

    // One write strobe per instruction
    single_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_rd_wen && !(s2_valid && s2_ready) |=> !s2_rd_wen)
    else begin
        $error("Register written twice without acceptance");
        fail_count++;
    end

    // Request drops and the stage frees up in the cycle after the ack
    ready_after_ack: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid && s2_cf_ack |=> s2_ready && !s2_cf_valid)
    else begin
        $error("Stage not ready or request still raised in the cycle after the ack");
        fail_count++;
    end

endmodule

bind exec_stage exec_assert i_exec_assert (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .s2_valid     (s2_valid),
    .s2_ready     (s2_ready),
    .s2_cf_valid  (s2_cf_valid),
    .s2_cf_ack    (s2_cf_ack),
    .s2_cf_target (s2_cf_target),
    .s2_rd_wen    (s2_rd_wen)
);

// ==== test/exec_tb.sv ====
// --------------------
// Execute stage testbench
// File driven instructions, fetch ack model, result checks and watchdog
// --------------------

module exec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // Constants
    localparam int        CLK_PERIOD_NS  = 8;
    localparam int        RESET_CYCLES   = 16;
    localparam int        DRIVE_DELAY    = 1;       // ns after rising edge
    localparam int        ACK_DELAY_MAX  = 3;       // Fetch ack delay in cycles
    localparam int        CYCLES_PER_VEC = 10;      // Watchdog budget per line
    localparam int        TAIL_CYCLES    = 8;       // Start and idle slack
    localparam int        MAX_VECS       = 64;
    localparam int        N_FIELDS       = 11;
    localparam bit [31:0] ACK_SEED       = 32'h095e_7dd8;
    localparam string     VEC_FILE       = "test/exec_input.txt";
    localparam int        F_ALU          = 0;       // Input file columns
    localparam int        F_CFU          = 1;
    localparam int        F_A            = 2;
    localparam int        F_B            = 3;
    localparam int        F_C            = 4;
    localparam int        F_PC           = 5;
    localparam int        F_RD           = 6;
    localparam int        F_WEN          = 7;       // Expected results from here
    localparam int        F_WDATA        = 8;
    localparam int        F_CF           = 9;
    localparam int        F_TARGET       = 10;

    // --------------------
    // DUT signals
    logic                g_clk;
    logic                g_resetn;
    logic                s2_valid;
    exec_pkg::word_t     s2_pc;
    exec_pkg::word_t     s2_opr_a;
    exec_pkg::word_t     s2_opr_b;
    exec_pkg::word_t     s2_opr_c;
    exec_pkg::reg_addr_t s2_rd;
    exec_pkg::alu_op_t   s2_alu_op;
    exec_pkg::cfu_op_t   s2_cfu_op;
    logic                s2_ready;
    logic                s2_cf_valid;
    logic                s2_cf_ack;
    exec_pkg::word_t     s2_cf_target;
    logic                s2_rd_wen;
    exec_pkg::reg_addr_t s2_rd_addr;
    exec_pkg::word_t     s2_rd_wdata;

    exec_pkg::word_t     vec [MAX_VECS][N_FIELDS];  // One row per input line
    int                  n_vecs       = 0;
    int                  cur_vec      = -1;         // Vector under test
    bit                  load_done    = 1'b0;
    int                  value_errors = 0;
    int                  flow_errors  = 0;

    exec_tb_clock #(
        .PERIOD_NS     (CLK_PERIOD_NS),
        .RESET_CYCLES  (RESET_CYCLES),
        .RELEASE_DELAY (DRIVE_DELAY)
    ) i_clock (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    exec_stage i_dut (.*);      // Port names match one to one

    // --------------------
    // Compare tasks
    task automatic check_word(input string name, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: vector %0d %s = %h, expected %h",
                     $time, cur_vec, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input exec_pkg::reg_addr_t got,
                              input exec_pkg::reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: vector %0d %s = %h, expected %h",
                     $time, cur_vec, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: vector %0d %s = %b, expected %b",
                     $time, cur_vec, name, got, exp);
        end
    endtask

    // --------------------
    // Stimulus
    task automatic load_vectors();
        int              fd;
        int              rc;
        string           line;
        exec_pkg::word_t f [N_FIELDS];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            flow_errors++;
            $display("Could not open stimulus file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (rc == N_FIELDS && n_vecs < MAX_VECS) begin
                    vec[n_vecs] = f;        // Comment lines scan no fields
                    n_vecs++;
                end
            end
        end
        $fclose(fd);
        if (n_vecs == 0) begin
            flow_errors++;
            $display("No instructions found in %s", VEC_FILE);
        end
    endtask

    task automatic drive_idle();
        s2_valid  = 1'b0;
        s2_pc     = '0;
        s2_opr_a  = '0;
        s2_opr_b  = '0;
        s2_opr_c  = '0;
        s2_rd     = '0;
        s2_alu_op = exec_pkg::ALU_OP_NOP;
        s2_cfu_op = exec_pkg::CFU_OP_NOP;
    endtask

    task automatic drive_vector(input int idx);
        cur_vec   = idx;
        s2_valid  = 1'b1;
        s2_alu_op = exec_pkg::alu_op_t'(vec[idx][F_ALU][3:0]);
        s2_cfu_op = exec_pkg::cfu_op_t'(vec[idx][F_CFU][3:0]);
        s2_opr_a  = vec[idx][F_A];
        s2_opr_b  = vec[idx][F_B];
        s2_opr_c  = vec[idx][F_C];
        s2_pc     = vec[idx][F_PC];
        s2_rd     = vec[idx][F_RD][exec_pkg::REG_ADDR_W-1:0];
    endtask

    // Present one instruction, watch every cycle until it is accepted
    task automatic run_instruction(input int idx);
        int n_writes;
        bit cf_seen;
        bit acked;
        bit first_cycle;
        bit accepted;
        n_writes    = 0;
        cf_seen     = 1'b0;
        acked       = 1'b0;
        first_cycle = 1'b1;
        accepted    = 1'b0;
        drive_vector(idx);
        while (!accepted) begin
            @(negedge g_clk);                               // Mid cycle with outputs settled
            if (first_cycle && vec[idx][F_CF][0] == 1'b0) begin
                check_bit("s2_ready", s2_ready, 1'b1);      // Ready in the first cycle
            end
            first_cycle = 1'b0;
            if (s2_rd_wen) begin
                n_writes++;
                check_addr("s2_rd_addr", s2_rd_addr, vec[idx][F_RD][exec_pkg::REG_ADDR_W-1:0]);
                check_word("s2_rd_wdata", s2_rd_wdata, vec[idx][F_WDATA]);
            end
            if (s2_cf_valid) begin
                cf_seen = 1'b1;
                acked   = acked || s2_cf_ack;
                check_word("s2_cf_target", s2_cf_target, vec[idx][F_TARGET]);
                check_bit("s2_ready", s2_ready, 1'b0);      // Held off until ack
            end
            accepted = s2_ready;
        end
        @(posedge g_clk);                                   // Acceptance edge
        #DRIVE_DELAY;
        check_bit("s2_rd_wen", n_writes != 0, vec[idx][F_WEN][0]);
        check_bit("s2_cf_valid", cf_seen, vec[idx][F_CF][0]);
        if (n_writes > 1) begin
            flow_errors++;
            $display("Vector %0d wrote its register %0d times", idx, n_writes);
        end
        if (cf_seen && !acked) begin
            flow_errors++;
            $display("Vector %0d left the stage before fetch acknowledged", idx);
        end
    endtask

    // --------------------
    // Fetch model acks a pending change 0 to 3 cycles late
    initial begin : fetch_model
        int unsigned delay;
        s2_cf_ack = 1'b0;
        void'($urandom(ACK_SEED));
        forever begin
            @(negedge g_clk);
            if (s2_cf_valid === 1'b1) begin
                delay = $urandom_range(ACK_DELAY_MAX, 0);
                repeat (delay + 1) @(posedge g_clk);
                #DRIVE_DELAY;
                s2_cf_ack = 1'b1;                           // Single cycle ack
                @(posedge g_clk);
                #DRIVE_DELAY;
                s2_cf_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (load_done);
        #((n_vecs * CYCLES_PER_VEC + RESET_CYCLES + TAIL_CYCLES) * CLK_PERIOD_NS);
        $display("Watchdog expired while vector %0d was in the stage", cur_vec);
        $display("Testbench failed");
        $finish;
    end

    // --------------------
    // Main sequence
    initial begin : stimulus
        int assert_fails;
        drive_idle();
        load_vectors();
        load_done = 1'b1;
        do begin
            @(negedge g_clk);
            if (g_resetn === 1'b0) begin                    // Quiet outputs in reset
                check_bit("s2_cf_valid", s2_cf_valid, 1'b0);
                check_bit("s2_rd_wen", s2_rd_wen, 1'b0);
            end
        end while (g_resetn !== 1'b1);
        @(posedge g_clk);
        #DRIVE_DELAY;
        for (int i = 0; i < n_vecs; i++) begin
            run_instruction(i);                             // Back to back issue
        end
        drive_idle();
        cur_vec = -1;
        repeat (2) begin
            @(negedge g_clk);
            check_bit("s2_cf_valid", s2_cf_valid, 1'b0);
            check_bit("s2_rd_wen", s2_rd_wen, 1'b0);
        end
        assert_fails = i_dut.i_exec_assert.fail_count;
        $display("%0d vectors, %0d value errors, %0d protocol errors, %0d assertion errors",
                 n_vecs, value_errors, flow_errors, assert_fails);
        if (value_errors + flow_errors + assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== test/exec_input.txt ====
// alu cfu opr_a opr_b opr_c pc rd, then expected rd_wen wdata cf_valid target (all hex)
// alu 0 nop 1 add 2 sub 3 xor 4 or 5 and 6 slt 7 sltu 8 srl 9 sll a sra, cfu 1 j 2 jal 3 jalr 4-9 branches
1 0 00000005 00000007 00000000 00001000 01 1 0000000c 0 00000000
1 0 ffffffff 00000002 00000000 00001004 02 1 00000001 0 00000000
2 0 00000003 00000005 00000000 00001008 03 1 fffffffe 0 00000000
2 0 80000000 00000001 00000000 0000100c 04 1 7fffffff 0 00000000
3 0 f0f0f0f0 0ff00ff0 00000000 00001010 05 1 ff00ff00 0 00000000
4 0 12340000 00005678 00000000 00001014 06 1 12345678 0 00000000
5 0 ff00ff00 0f0f0f0f 00000000 00001018 07 1 0f000f00 0 00000000
6 0 ffffffff 00000001 00000000 0000101c 08 1 00000001 0 00000000
7 0 ffffffff 00000001 00000000 00001020 09 1 00000000 0 00000000
7 0 00000001 ffffffff 00000000 00001024 0b 1 00000001 0 00000000
8 0 80000000 00000004 00000000 00001028 0c 1 08000000 0 00000000
a 0 80000000 00000004 00000000 0000102c 0d 1 f8000000 0 00000000
9 0 00000001 0000003f 00000000 00001030 0f 1 80000000 0 00000000
8 0 0000ff00 00000024 00000000 00001034 10 1 00000ff0 0 00000000
0 0 12345678 00000001 00000000 00001038 11 0 00000000 0 00000000
0 4 00000010 00000010 00000020 00002000 00 0 00000000 1 00002020
0 4 00000010 00000011 00000020 00002004 00 0 00000000 0 00000000
0 5 00000001 00000002 fffffff0 00002100 00 0 00000000 1 000020f0
0 6 fffffffe 00000001 00000008 00003000 00 0 00000000 1 00003008
0 7 fffffffe 00000001 00000008 00003004 00 0 00000000 0 00000000
0 8 00000005 fffffffb 00000100 00004000 00 0 00000000 1 00004100
0 8 00000007 00000007 00000004 00004400 00 0 00000000 1 00004404
0 9 00000001 80000000 00000010 00004800 00 0 00000000 0 00000000
0 7 00000001 80000000 fffff000 00005000 00 0 00000000 1 00004000
0 1 00006000 00000010 00000000 00006000 00 0 00000000 1 00006010
1 2 00007000 00000100 00007004 00007000 01 1 00007004 1 00007100
1 3 00008001 00000004 00009004 00009000 1f 1 00009004 1 00008004
1 2 0000c000 fffff000 0000c004 0000c000 1e 1 0000c004 1 0000b000
1 0 00000100 00000023 00000000 0000c004 1d 1 00000123 0 00000000

// ==== files.f ====
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_cfu.sv
verilog/exec_writeback.sv
verilog/exec_stage.sv
test/exec_tb_clock.sv
test/exec_assert.sv
test/exec_tb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/100ps
TOP      := exec_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Testbench passed

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
